// ==== cache_pkg.sv ====
package cache_pkg;

	// Address split into tag [15:8], index [7:2] and offset [1:0]
	localparam int ADDR_W    = 16;                // CPU word address width
	localparam int WORD_W    = 16;                // Data word width
	localparam int LINE_W    = 64;                // Four words per line
	localparam int TAG_W     = 8;
	localparam int INDEX_W   = 6;
	localparam int OFFS_W    = 2;
	localparam int MADDR_W   = 14;                // Line address, tag then index
	localparam int NUM_LINES = 64;                // Lines per cache
	localparam int MEM_LINES = 1 << MADDR_W;      // Lines in main memory
	localparam int MEM_LAT   = 4;                 // Memory access latency in cycles
	localparam int CNT_W     = $clog2(MEM_LAT + 1); // Latency counter width
	localparam logic [WORD_W-1:0] MEM_KEY = 16'hA5A5; // Initial memory pattern key

	// Controller state encoding
	typedef enum logic [1:0] {
		ST_IDLE         = 2'b00, // Answer hits, launch misses
		ST_EXTRA        = 2'b01, // Gap cycle after write-back, starts the fill read
		ST_SERVICE_MISS = 2'b10, // Wait for fill data
		ST_WRITE_BACK   = 2'b11  // Dirty victim going out
	} ctrl_state_e;

	// One line seen either as a raw vector or as four words
	typedef union packed {
		logic [LINE_W-1:0]             raw;   // Memory transfer and storage
		logic [3:0][WORD_W-1:0]        words; // Word 0 in the low bits
	} cache_line_u;

endpackage

// ==== icache.sv ====
`timescale 1ns/1ps

module icache (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cache_pkg::ADDR_W-1:0]   i_addr,  // Fetch address
	input  logic                           i_we,    // Fill strobe from controller
	input  cache_pkg::cache_line_u         i_line,  // Fill line
	output logic                           o_hit,
	output logic [cache_pkg::WORD_W-1:0]   o_word   // Fetched instruction word
);

	import cache_pkg::*;

	logic [TAG_W-1:0]     tag_mem  [NUM_LINES]; // Stored tags
	cache_line_u          line_mem [NUM_LINES]; // Stored lines
	logic [NUM_LINES-1:0] valid;                // Per-line valid bits

	logic [TAG_W-1:0]     tag;
	logic [INDEX_W-1:0]   idx;
	logic [OFFS_W-1:0]    offs;
	cache_line_u          rd_line;              // Indexed line

	assign tag  = i_addr[15:8];
	assign idx  = i_addr[7:2];
	assign offs = i_addr[1:0];

	// Each fill sets the valid bit of its index
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (i_we) begin
			valid[idx] <= 1'b1;
		end
	end

	// Tag and line arrays
	always_ff @(posedge clk) begin
		if (i_we) begin
			tag_mem[idx]  <= tag;
			line_mem[idx] <= i_line;
		end
	end

	assign rd_line = line_mem[idx];
	assign o_hit   = valid[idx] && (tag_mem[idx] == tag); // Direct-mapped compare
	assign o_word  = rd_line.words[offs];                 // Word select by offset

endmodule

// ==== dcache.sv ====
`timescale 1ns/1ps

module dcache (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cache_pkg::ADDR_W-1:0]   i_addr,  // Load or store address
	input  logic                           i_we,    // Line write strobe from controller
	input  cache_pkg::cache_line_u         i_line,  // Fill or merged line
	input  logic                           i_dirty, // Dirty bit to store with the line
	output logic                           o_hit,
	output logic                           o_dirty, // Indexed entry holds modified data
	output logic [cache_pkg::TAG_W-1:0]    o_tag,   // Victim tag for write-back
	output cache_pkg::cache_line_u         o_line,  // Indexed line, victim or merge base
	output logic [cache_pkg::WORD_W-1:0]   o_word   // Load data
);

	import cache_pkg::*;

	logic [TAG_W-1:0]     tag_mem  [NUM_LINES]; // Stored tags
	cache_line_u          line_mem [NUM_LINES]; // Stored lines
	logic [NUM_LINES-1:0] valid;
	logic [NUM_LINES-1:0] dirty;                // Modified since fill

	logic [TAG_W-1:0]     tag;
	logic [INDEX_W-1:0]   idx;
	logic [OFFS_W-1:0]    offs;
	cache_line_u          rd_line;

	assign tag  = i_addr[15:8];
	assign idx  = i_addr[7:2];
	assign offs = i_addr[1:0];

	// Valid and dirty bits per line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_we) begin
			valid[idx] <= 1'b1;
			dirty[idx] <= i_dirty; // Clean on load fill, set on store
		end
	end

	always_ff @(posedge clk) begin
		if (i_we) begin
			tag_mem[idx]  <= tag;
			line_mem[idx] <= i_line;
		end
	end

	assign rd_line = line_mem[idx];

	// Lookup of the indexed entry
	assign o_hit   = valid[idx] && (tag_mem[idx] == tag);
	assign o_dirty = valid[idx] && dirty[idx]; // Only a valid line can need write-back
	assign o_tag   = tag_mem[idx];
	assign o_line  = rd_line;
	assign o_word  = rd_line.words[offs];

endmodule

// ==== cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cache_pkg::ADDR_W-1:0]   i_iaddr,   // Fetch address
	input  logic [cache_pkg::ADDR_W-1:0]   i_daddr,   // Data address
	input  logic [cache_pkg::WORD_W-1:0]   i_wr_data, // Store data
	input  logic                           i_iacc,    // Fetch access
	input  logic                           i_dacc,    // Data access
	input  logic                           i_write,   // Data access is a store
	input  logic                           i_ihit,
	input  logic                           i_dhit,
	input  logic                           i_dirty,   // Indexed data line is dirty
	input  logic                           i_mem_rdy,
	input  logic [cache_pkg::TAG_W-1:0]    i_dtag,    // Victim tag
	input  cache_pkg::cache_line_u         i_dline,   // Indexed data line
	input  cache_pkg::cache_line_u         i_mline,   // Line read from memory
	output logic                           o_iwe,
	output cache_pkg::cache_line_u         o_iline,
	output logic                           o_dwe,
	output cache_pkg::cache_line_u         o_dline,
	output logic                           o_ddirty,
	output logic                           o_mre,
	output logic                           o_mwe,
	output logic [cache_pkg::MADDR_W-1:0]  o_maddr,
	output cache_pkg::cache_line_u         o_mline,
	output logic                           o_rdy
);

	import cache_pkg::*;

	ctrl_state_e        state;
	ctrl_state_e        next_state;
	logic               d_miss;
	logic               i_miss;
	logic [OFFS_W-1:0]  d_offs;
	logic [MADDR_W-1:0] d_line_addr;  // Line address of the data request
	logic [MADDR_W-1:0] i_line_addr;  // Line address of the fetch request
	logic [MADDR_W-1:0] wb_addr;      // Line address of the dirty victim
	cache_line_u        merged;       // Line with the store word replaced

	assign d_miss      = i_dacc && !i_dhit;
	assign i_miss      = i_iacc && !i_ihit;
	assign d_offs      = i_daddr[1:0];
	assign d_line_addr = i_daddr[15:2];
	assign i_line_addr = i_iaddr[15:2];
	assign wb_addr     = {i_dtag, i_daddr[7:2]}; // Victim tag plus current index

	// Store word merged into the cached line on a hit or the fill line on a miss
	always_comb begin
		merged = (state == ST_SERVICE_MISS) ? i_mline : i_dline;
		merged.words[d_offs] = i_wr_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		o_iwe      = 1'b0;
		o_iline    = i_mline;   // Fetch fills always come from memory
		o_dwe      = 1'b0;
		o_dline    = i_mline;
		o_ddirty   = 1'b0;
		o_mre      = 1'b0;
		o_mwe      = 1'b0;
		o_maddr    = '0;
		o_mline    = i_dline;   // Only ever written back as the victim
		o_rdy      = 1'b0;
		next_state = ST_IDLE;

		case (state)
			ST_IDLE: begin
				if (d_miss) begin                 // Data side wins arbitration
					if (i_dirty) begin
						o_mwe      = 1'b1;          // Victim goes out first
						o_maddr    = wb_addr;
						next_state = ST_WRITE_BACK;
					end else begin
						o_mre      = 1'b1;
						o_maddr    = d_line_addr;
						next_state = ST_SERVICE_MISS;
					end
				end else if (i_miss) begin
					o_mre      = 1'b1;
					o_maddr    = i_line_addr;
					next_state = ST_SERVICE_MISS;
				end else begin
					o_rdy = 1'b1;                  // Everything asserted hits
					if (i_dacc && i_write) begin
						o_dwe    = 1'b1;              // Store hit, written at the same edge
						o_dline  = merged;
						o_ddirty = 1'b1;
					end
				end
			end

			ST_SERVICE_MISS: begin
				if (i_mem_rdy) begin
					if (d_miss) begin
						o_dwe = 1'b1;
						if (i_write) begin
							o_dline  = merged;          // Store miss fills a dirty line
							o_ddirty = 1'b1;
						end
					end else begin
						o_iwe = 1'b1;               // Data hits, so this was the fetch
					end
					next_state = ST_IDLE;          // Access hits on the next cycle
				end else if (d_miss) begin
					o_mre      = 1'b1;             // Hold the read
					o_maddr    = d_line_addr;
					next_state = ST_SERVICE_MISS;
				end else if (i_miss) begin
					o_mre      = 1'b1;
					o_maddr    = i_line_addr;
					next_state = ST_SERVICE_MISS;
				end
			end

			ST_WRITE_BACK: begin
				o_mwe   = 1'b1;                   // Hold the write until memory is done
				o_maddr = wb_addr;
				if (i_mem_rdy) begin
					next_state = ST_EXTRA;
				end else begin
					next_state = ST_WRITE_BACK;
				end
			end

			ST_EXTRA: begin
				// Memory is idle again after the write so the fill read starts here
				o_mre      = 1'b1;
				o_maddr    = d_line_addr;
				next_state = ST_SERVICE_MISS;
			end

			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

endmodule

// ==== unified_mem.sv ====
`timescale 1ns/1ps

module unified_mem (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_re,    // Line read request
	input  logic                           i_we,    // Line write request
	input  logic [cache_pkg::MADDR_W-1:0]  i_addr,  // Line address
	input  cache_pkg::cache_line_u         i_line,  // Write data
	output cache_pkg::cache_line_u         o_line,  // Read data, valid with o_rdy
	output logic                           o_rdy    // One-cycle completion pulse
);

	import cache_pkg::*;

	cache_line_u      mem [MEM_LINES]; // Whole address space, one entry per line
	logic [CNT_W-1:0] cnt;             // Cycles spent on the current request
	logic             last;            // Final latency cycle of a held request

	// Word address a holds a XOR key
	initial begin
		for (int l = 0; l < MEM_LINES; l++) begin
			for (int w = 0; w < 4; w++) begin
				mem[l].words[w] = ADDR_W'(l * 4 + w) ^ MEM_KEY;
			end
		end
	end

	assign last = (i_re || i_we) && !o_rdy && (cnt == CNT_W'(MEM_LAT - 1));

	// Latency counter and ready pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt   <= '0;
			o_rdy <= 1'b0;
		end else if (o_rdy) begin
			cnt   <= '0;                    // Back to idle after the pulse
			o_rdy <= 1'b0;
		end else if (last) begin
			cnt   <= '0;
			o_rdy <= 1'b1;
		end else if (i_re || i_we) begin
			cnt   <= cnt + 1'b1;
		end else begin
			cnt   <= '0;                    // Dropped request restarts the count
		end
	end

	// Array access at the edge that raises o_rdy
	always_ff @(posedge clk) begin
		if (last && i_we) begin
			mem[i_addr] <= i_line;          // Committed before o_rdy is seen
		end
		if (last && i_re) begin
			o_line <= mem[i_addr];
		end
	end

endmodule

// ==== cache_subsystem.sv ====
`timescale 1ns/1ps

module cache_subsystem (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_fetch_acc,
	input  logic [cache_pkg::ADDR_W-1:0]   i_fetch_addr,
	input  logic                           i_data_acc,
	input  logic [cache_pkg::ADDR_W-1:0]   i_data_addr,
	input  logic                           i_data_rd,
	input  logic                           i_data_wr,
	input  logic [cache_pkg::WORD_W-1:0]   i_wr_data,
	output logic [cache_pkg::WORD_W-1:0]   o_fetch_data,
	output logic [cache_pkg::WORD_W-1:0]   o_rd_data,
	output logic                           o_rdy
);

	import cache_pkg::*;

	logic               data_acc;   // Data access with a read or write strobe
	logic               i_hit;
	logic               i_we;
	cache_line_u        i_data;
	logic               d_hit;
	logic               dirty;
	logic [TAG_W-1:0]   d_tag;
	cache_line_u        d_line;
	logic               d_we;
	cache_line_u        d_data;
	logic               d_dirt_in;
	logic               m_re;
	logic               m_we;
	logic [MADDR_W-1:0] m_addr;
	cache_line_u        m_data;
	cache_line_u        m_line;
	logic               mem_rdy;

	assign data_acc = i_data_acc && (i_data_rd || i_data_wr);

	icache u_icache (
		.clk(clk), .rst_n(rst_n), .i_addr(i_fetch_addr), .i_we(i_we), .i_line(i_data),
		.o_hit(i_hit), .o_word(o_fetch_data)
	);

	dcache u_dcache (
		.clk(clk), .rst_n(rst_n), .i_addr(i_data_addr), .i_we(d_we), .i_line(d_data),
		.i_dirty(d_dirt_in), .o_hit(d_hit), .o_dirty(dirty), .o_tag(d_tag),
		.o_line(d_line), .o_word(o_rd_data)
	);

	cache_controller u_ctrl (
		.clk(clk), .rst_n(rst_n), .i_iaddr(i_fetch_addr), .i_daddr(i_data_addr),
		.i_wr_data(i_wr_data), .i_iacc(i_fetch_acc), .i_dacc(data_acc), .i_write(i_data_wr),
		.i_ihit(i_hit), .i_dhit(d_hit), .i_dirty(dirty), .i_mem_rdy(mem_rdy),
		.i_dtag(d_tag), .i_dline(d_line), .i_mline(m_line),
		.o_iwe(i_we), .o_iline(i_data), .o_dwe(d_we), .o_dline(d_data),
		.o_ddirty(d_dirt_in), .o_mre(m_re), .o_mwe(m_we), .o_maddr(m_addr),
		.o_mline(m_data), .o_rdy(o_rdy)
	);

	unified_mem u_mem (
		.clk(clk), .rst_n(rst_n), .i_re(m_re), .i_we(m_we), .i_addr(m_addr),
		.i_line(m_data), .o_line(m_line), .o_rdy(mem_rdy)
	);

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;         // 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);    // Ten cycles in reset
		@(negedge clk);
		rst_n = 1'b1;                  // Released away from the active edge
	end

endmodule

// ==== tb_cache_subsystem.sv ====
`timescale 1ns/1ps

module tb_cache_subsystem;

	import cache_pkg::*;

	logic              clk;
	logic              rst_n;
	logic              fetch_acc;
	logic [ADDR_W-1:0] fetch_addr;
	logic              data_acc;
	logic [ADDR_W-1:0] data_addr;
	logic              data_rd;
	logic              data_wr;
	logic [WORD_W-1:0] wr_data;
	logic [WORD_W-1:0] fetch_data;
	logic [WORD_W-1:0] rd_data;
	logic              rdy;

	logic [WORD_W-1:0] shadow [1 << ADDR_W]; // Last value stored per word address
	bit                stored [1 << ADDR_W]; // Word has been written by a store
	logic [31:0]       lfsr;                 // Random state
	int                wait_cycles;          // Edges until o_rdy on the last access

	tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

	cache_subsystem DUT (
		.clk(clk), .rst_n(rst_n), .i_fetch_acc(fetch_acc), .i_fetch_addr(fetch_addr),
		.i_data_acc(data_acc), .i_data_addr(data_addr), .i_data_rd(data_rd),
		.i_data_wr(data_wr), .i_wr_data(wr_data), .o_fetch_data(fetch_data),
		.o_rd_data(rd_data), .o_rdy(rdy)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);      // One step per bit
			v    = {v[14:0], lfsr[31]};
		end
	endtask

	// Expected memory content of one word
	function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
		if (stored[addr]) begin
			return shadow[addr];
		end
		return addr ^ 16'hA5A5;          // Power-up pattern
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_fetch(input logic [ADDR_W-1:0] addr,
			input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch o_fetch_data at %h: got %h, expected %h",
				addr, got, exp));
		end
	endtask

	task automatic check_load(input logic [ADDR_W-1:0] addr,
			input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch o_rd_data at %h: got %h, expected %h",
				addr, got, exp));
		end
	endtask

	task automatic check_rdy(input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch o_rdy: got %h, expected %h", got, exp));
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (!rst_n && n < 40) begin
			@(posedge clk);
			n++;
		end
		if (!rst_n) begin
			report_failure("reset was still asserted after 40 cycles");
		end
	endtask

	// Present one request on the falling edge and hold it until o_rdy
	task automatic run_access(input logic f_acc, input logic [ADDR_W-1:0] f_addr,
			input logic d_acc, input logic d_wr, input logic [ADDR_W-1:0] d_addr,
			input logic [WORD_W-1:0] wdata);
		@(negedge clk);
		fetch_acc  = f_acc;
		fetch_addr = f_addr;
		data_acc   = d_acc;
		data_addr  = d_addr;
		data_rd    = d_acc && !d_wr;     // A data access is either a load or a store
		data_wr    = d_acc && d_wr;
		wr_data    = wdata;
		wait_cycles = 0;
		do begin
			@(posedge clk);
			wait_cycles++;
		end while (!rdy && wait_cycles < 200);
		if (!rdy) begin
			report_failure("o_rdy did not rise within 200 cycles of an access");
		end
	endtask

	// Compare at the transfer edge, then record the store
	always @(posedge clk) begin
		if (rst_n && rdy) begin
			if (fetch_acc) begin
				check_fetch(fetch_addr, fetch_data, ref_word(fetch_addr));
			end
			if (data_acc && data_rd && !data_wr) begin
				check_load(data_addr, rd_data, ref_word(data_addr));
			end
			if (data_acc && data_wr) begin
				shadow[data_addr] = wr_data;
				stored[data_addr] = 1'b1;
			end
		end
	end

	initial begin
		logic [15:0] op;
		logic [15:0] dsel;
		logic [15:0] fsel;
		logic [15:0] wd;
		logic        f_en;
		logic        d_en;
		logic        w_en;
		fetch_acc  = 1'b0;
		fetch_addr = '0;
		data_acc   = 1'b0;
		data_addr  = '0;
		data_rd    = 1'b0;
		data_wr    = 1'b0;
		wr_data    = '0;
		lfsr       = 32'h4807_c40f;
		wait_reset();

		@(negedge clk);
		check_rdy(rdy, 1'b1);            // Idle, nothing asserted

		// First fetch and load both miss and see the power-up pattern
		run_access(1'b1, 16'h4014, 1'b1, 1'b0, 16'h1024, 16'h0000);
		if (wait_cycles < 2 * MEM_LAT) begin
			report_failure("first fetch and load completed without going to memory");
		end

		// Same lines again answered at once
		run_access(1'b1, 16'h4015, 1'b1, 1'b0, 16'h1025, 16'h0000);
		if (wait_cycles != 1) begin
			report_failure("repeated fetch and load were not answered in one cycle");
		end

		// Store hit then a read of the whole line
		run_access(1'b0, 16'h0000, 1'b1, 1'b1, 16'h1026, 16'hBEEF);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, 16'h1026, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, 16'h1024, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, 16'h1025, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, 16'h1027, 16'h0000);

		// Store miss and a conflicting tag that evicts the dirty line before the reload
		run_access(1'b0, 16'h0000, 1'b1, 1'b1, 16'h1030, 16'h1234);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, 16'h1031, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, 16'h1130, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, 16'h1030, 16'h0000);

		// Dirty data miss together with a fetch miss
		run_access(1'b0, 16'h0000, 1'b1, 1'b1, 16'h1240, 16'hC0DE);
		run_access(1'b1, 16'h4240, 1'b1, 1'b0, 16'h1340, 16'h0000);
		if (wait_cycles < 3 * MEM_LAT) begin
			report_failure("write-back, fill and fetch finished faster than three accesses");
		end
		run_access(1'b1, 16'h4241, 1'b1, 1'b0, 16'h1240, 16'h0000);

		// Random mix over few tags so lines conflict and get dirty
		for (int k = 0; k < 2000; k++) begin
			take_bits(3, op);
			take_bits(7, dsel);
			take_bits(7, fsel);
			take_bits(16, wd);
			f_en = (op[1:0] == 2'd0) || (op[1:0] == 2'd3);
			d_en = (op[1:0] != 2'd0);
			w_en = (op[1:0] == 2'd2) || ((op[1:0] == 2'd3) && op[2]);
			run_access(f_en, {6'b010000, fsel[6:5], 3'b000, fsel[4:0]},
				d_en, w_en, {6'b000100, dsel[6:5], 3'b000, dsel[4:0]}, wd);
		end

		@(negedge clk);
		fetch_acc = 1'b0;
		data_acc  = 1'b0;
		data_rd   = 1'b0;
		data_wr   = 1'b0;
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== list.f ====
cache_pkg.sv
icache.sv
dcache.sv
cache_controller.sv
unified_mem.sv
cache_subsystem.sv
tb_clk_gen.sv
tb_cache_subsystem.sv

// ==== Makefile ====
TOP = tb_cache_subsystem

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --top-module cache_subsystem cache_pkg.sv icache.sv \
		dcache.sv cache_controller.sv unified_mem.sv cache_subsystem.sv

clean:
	rm -rf obj_dir
